// File: rtl/adc_capture_top.sv
`timescale 1ns/1ps

module adc_capture_top import scope_pkg::*; (
    input  logic                    adc_sampleclk,
    input  logic                    reset,
    input  logic                    arm_i,
    input  logic                    adc_capture_go_i,
    input  sample_t                 adc_datain_i,
    input  logic [PRESAMPLE_W-1:0]  presample_i,
    input  logic [MAXSAMP_W-1:0]    max_samples_i,
    input  logic [DOWNSAMPLE_W-1:0] downsample_i,
    input  logic                    low_res_i,
    input  logic                    low_res_lsb_i,
    input  logic                    no_clip_errors_i,
    input  logic                    clear_errors_i,
    input  logic                    credit_i,
    output byte_beat_t              byte_o,
    output logic                    adc_capture_stop_o,
    output logic                    error_flag_o,
    output capture_err_t            error_stat_o
);

    capture_cfg_t   cfg;
    capture_err_t   err_evt;
    capture_state_t state;
    logic           smp_wr;
    logic           fsm_drain;
    logic           pack_rd;
    logic           smp_rd;
    logic           smp_full;
    logic           smp_empty;
    sample_t        smp_dout;
    logic           pack_en;
    logic           word_wr;
    word_t          word_din;
    logic           word_rd;
    logic           word_full;
    logic           word_empty;
    word_t          word_dout;

    assign smp_rd = fsm_drain | pack_rd;  // never both, pack_en excludes PRESAMP_FULL

    capture_regs u_capture_regs (
        .adc_sampleclk    (adc_sampleclk),
        .reset            (reset),
        .arm_i            (arm_i),
        .state_i          (state),
        .presample_i      (presample_i),
        .max_samples_i    (max_samples_i),
        .downsample_i     (downsample_i),
        .low_res_i        (low_res_i),
        .low_res_lsb_i    (low_res_lsb_i),
        .no_clip_errors_i (no_clip_errors_i),
        .clear_errors_i   (clear_errors_i),
        .err_evt_i        (err_evt),
        .cfg_o            (cfg),
        .error_flag_o     (error_flag_o),
        .error_stat_o     (error_stat_o)
    );

    capture_fsm u_capture_fsm (
        .adc_sampleclk    (adc_sampleclk),
        .reset            (reset),
        .arm_i            (arm_i),
        .adc_capture_go_i (adc_capture_go_i),
        .adc_datain_i     (adc_datain_i),
        .cfg_i            (cfg),
        .fifo_full_i      (smp_full),
        .fifo_empty_i     (smp_empty),
        .fifo_wr_o        (smp_wr),
        .fifo_drain_o     (fsm_drain),
        .pack_en_o        (pack_en),
        .capture_stop_o   (adc_capture_stop_o),
        .state_o          (state),
        .err_evt_o        (err_evt)
    );

    sample_fifo #(.payload_t(sample_t), .DEPTH(SAMPLE_DEPTH)) u_sample_fifo (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .wr_en_i       (smp_wr),
        .din_i         (adc_datain_i),
        .rd_en_i       (smp_rd),
        .dout_o        (smp_dout),
        .full_o        (smp_full),
        .empty_o       (smp_empty)
    );

    sample_packer u_sample_packer (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .pack_en_i     (pack_en),
        .smp_empty_i   (smp_empty),
        .smp_dout_i    (smp_dout),
        .smp_rd_o      (pack_rd),
        .word_full_i   (word_full),
        .word_wr_o     (word_wr),
        .word_o        (word_din)
    );

    sample_fifo #(.payload_t(word_t), .DEPTH(WORD_DEPTH)) u_word_fifo (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .wr_en_i       (word_wr),
        .din_i         (word_din),
        .rd_en_i       (word_rd),
        .dout_o        (word_dout),
        .full_o        (word_full),
        .empty_o       (word_empty)
    );

    byte_reader u_byte_reader (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .cfg_i         (cfg),
        .word_empty_i  (word_empty),
        .word_dout_i   (word_dout),
        .word_rd_o     (word_rd),
        .credit_i      (credit_i),
        .byte_o        (byte_o)
    );

endmodule

// File: rtl/byte_reader.sv
`timescale 1ns/1ps

module byte_reader import scope_pkg::*; (
    input  logic         adc_sampleclk,
    input  logic         reset,
    input  capture_cfg_t cfg_i,
    input  logic         word_empty_i,
    input  word_t        word_dout_i,
    output logic         word_rd_o,
    input  logic         credit_i,
    output byte_beat_t   byte_o
);

    logic [CREDIT_W-1:0] credit_cnt;
    logic [3:0]          byte_idx;
    logic [3:0]          last_idx;
    logic [3:0]          nib_r;     // low nibble of word A in hi-res
    sample_t             lr_smp;
    logic [7:0]          byte_sel;
    logic                fire;

    assign fire      = (credit_cnt != '0) && !word_empty_i;
    assign last_idx  = cfg_i.low_res ? 4'd2 : 4'd8;  // 3 bytes per word, 9 per pair
    assign word_rd_o = fire && ((byte_idx == last_idx) || (!cfg_i.low_res && (byte_idx == 4'd3)));
    assign lr_smp    = word_dout_i[(2 - int'(byte_idx)) * SAMPLE_W +: SAMPLE_W];

    always_comb begin
        byte_sel = 8'h00;
        if (cfg_i.low_res) begin
            byte_sel = cfg_i.low_res_lsb ? lr_smp[7:0] : lr_smp[11:4];
        end else begin
            case (byte_idx)
                4'd0:    byte_sel = word_dout_i[35:28];
                4'd1:    byte_sel = word_dout_i[27:20];
                4'd2:    byte_sel = word_dout_i[19:12];
                4'd3:    byte_sel = word_dout_i[11:4];
                4'd4:    byte_sel = {nib_r, word_dout_i[35:32]};  // word B now at head
                4'd5:    byte_sel = word_dout_i[31:24];
                4'd6:    byte_sel = word_dout_i[23:16];
                4'd7:    byte_sel = word_dout_i[15:8];
                4'd8:    byte_sel = word_dout_i[7:0];
                default: byte_sel = 8'h00;
            endcase
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            credit_cnt   <= CREDIT_W'(CREDIT_MAX);
            byte_idx     <= '0;
            byte_o.valid <= 1'b0;
        end else begin
            credit_cnt   <= credit_cnt - CREDIT_W'(fire) + CREDIT_W'(credit_i);
            byte_o.valid <= fire;
            if (fire) begin
                byte_idx <= (byte_idx == last_idx) ? '0 : byte_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        byte_o.data <= byte_sel;
        if (fire && !cfg_i.low_res && (byte_idx == 4'd3)) begin
            nib_r <= word_dout_i[3:0];  // kept across the pop of A
        end
    end

    // host returns one credit per accepted byte, never more
    assert property (@(posedge adc_sampleclk) disable iff (reset) credit_cnt <= CREDIT_MAX);

endmodule

// File: rtl/capture_fsm.sv
`timescale 1ns/1ps

module capture_fsm import scope_pkg::*; (
    input  logic           adc_sampleclk,
    input  logic           reset,
    input  logic           arm_i,
    input  logic           adc_capture_go_i,
    input  sample_t        adc_datain_i,
    input  capture_cfg_t   cfg_i,
    input  logic           fifo_full_i,
    input  logic           fifo_empty_i,
    output logic           fifo_wr_o,
    output logic           fifo_drain_o,
    output logic           pack_en_o,
    output logic           capture_stop_o,
    output capture_state_t state_o,
    output capture_err_t   err_evt_o
);

    capture_state_t          state;
    logic                    arm_r;
    logic                    arm_go;
    logic [DOWNSAMPLE_W-1:0] ds_cnt;
    logic                    keep;
    logic [PRESAMPLE_W-1:0]  pre_cnt;
    logic [MAXSAMP_W-1:0]    kept_cnt;
    logic                    pre_full;
    logic                    fill_wr;
    logic                    wr_req;
    logic                    stop_r;

    assign arm_go = arm_i && !arm_r && (state == IDLE);
    assign keep   = (ds_cnt == '0);  // one kept sample every downsample+1 cycles

    // with presample at zero the window is full at once and FILLING just waits for go
    assign pre_full = (pre_cnt == cfg_i.presample);
    assign fill_wr  = keep && (state == PRESAMP_FILLING) && !pre_full;
    assign wr_req   = fill_wr || (keep && ((state == PRESAMP_FULL) || (state == TRIGGERED)));

    assign fifo_wr_o      = wr_req && !fifo_full_i;  // dropped when full
    assign fifo_drain_o   = keep && (state == PRESAMP_FULL);  // keeps window at presample
    assign pack_en_o      = (state == TRIGGERED) || (state == DONE);
    assign capture_stop_o = stop_r;
    assign state_o        = state;

    assign err_evt_o.downsample_err = (state != IDLE) && (cfg_i.downsample != '0)
                                      && (cfg_i.presample != '0);
    assign err_evt_o.clip_err       = wr_req && !cfg_i.no_clip_errors
                                      && ((adc_datain_i == '1) || (adc_datain_i == '0));
    assign err_evt_o.presamp_err    = adc_capture_go_i && (state == PRESAMP_FILLING) && !pre_full;
    assign err_evt_o.overflow_err   = wr_req && fifo_full_i;

    always_ff @(posedge adc_sampleclk) begin
        if (reset || arm_go) begin
            ds_cnt <= '0;
        end else if (ds_cnt == cfg_i.downsample) begin
            ds_cnt <= '0;
        end else begin
            ds_cnt <= ds_cnt + 1'b1;
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            state    <= IDLE;
            arm_r    <= 1'b0;
            pre_cnt  <= '0;
            kept_cnt <= '0;
            stop_r   <= 1'b0;
        end else begin
            arm_r <= arm_i;
            case (state)
                IDLE: begin
                    if (arm_go) begin
                        pre_cnt <= '0;
                        stop_r  <= 1'b0;  // held from last capture until now
                        state   <= PRESAMP_FILLING;
                    end
                end
                PRESAMP_FILLING: begin
                    if (fill_wr) begin
                        pre_cnt <= pre_cnt + 1'b1;
                    end
                    if (adc_capture_go_i) begin
                        kept_cnt <= MAXSAMP_W'(pre_cnt) + MAXSAMP_W'(fill_wr);
                        state    <= TRIGGERED;
                    end else if (fill_wr && (pre_cnt + 1'b1 == cfg_i.presample)) begin
                        state <= PRESAMP_FULL;
                    end
                end
                PRESAMP_FULL: begin
                    if (adc_capture_go_i) begin
                        kept_cnt <= MAXSAMP_W'(pre_cnt);  // window counts toward total
                        state    <= TRIGGERED;
                    end
                end
                TRIGGERED: begin
                    if (keep) begin
                        kept_cnt <= kept_cnt + 1'b1;
                        if (kept_cnt == cfg_i.max_samples - 1'b1) begin
                            stop_r <= 1'b1;
                            state  <= DONE;
                        end
                    end
                end
                DONE: begin
                    if (fifo_empty_i) begin  // packer has taken every sample
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // the drain only runs against a window of presample entries
    assert property (@(posedge adc_sampleclk) disable iff (reset)
        fifo_drain_o |-> fifo_wr_o && !fifo_empty_i);

endmodule

// File: rtl/capture_regs.sv
`timescale 1ns/1ps

module capture_regs import scope_pkg::*; (
    input  logic                    adc_sampleclk,
    input  logic                    reset,
    input  logic                    arm_i,
    input  capture_state_t          state_i,
    input  logic [PRESAMPLE_W-1:0]  presample_i,
    input  logic [MAXSAMP_W-1:0]    max_samples_i,
    input  logic [DOWNSAMPLE_W-1:0] downsample_i,
    input  logic                    low_res_i,
    input  logic                    low_res_lsb_i,
    input  logic                    no_clip_errors_i,
    input  logic                    clear_errors_i,
    input  capture_err_t            err_evt_i,
    output capture_cfg_t            cfg_o,
    output logic                    error_flag_o,
    output capture_err_t            error_stat_o
);

    logic         arm_r;
    logic         arm_go;
    capture_err_t stat_next;

    assign arm_go    = arm_i && !arm_r && (state_i == IDLE);  // new capture starts
    assign stat_next = capture_err_t'(error_stat_o | err_evt_i);

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            arm_r        <= 1'b0;
            cfg_o        <= '0;
            error_stat_o <= '0;
            error_flag_o <= 1'b0;
        end else begin
            arm_r <= arm_i;
            if (arm_go) begin
                cfg_o.presample      <= presample_i;
                cfg_o.max_samples    <= max_samples_i;
                cfg_o.downsample     <= downsample_i;
                cfg_o.low_res        <= low_res_i;
                cfg_o.low_res_lsb    <= low_res_lsb_i;
                cfg_o.no_clip_errors <= no_clip_errors_i;
            end
            if (clear_errors_i || arm_go) begin
                error_stat_o <= '0;
                error_flag_o <= 1'b0;
            end else begin
                error_stat_o <= stat_next;  // sticky
                error_flag_o <= |stat_next;
            end
        end
    end

endmodule

// File: rtl/sample_fifo.sv
`timescale 1ns/1ps

module sample_fifo import scope_pkg::*; #(
    parameter type payload_t = sample_t,
    parameter int  DEPTH     = SAMPLE_DEPTH
) (
    input  logic     adc_sampleclk,
    input  logic     reset,
    input  logic     wr_en_i,
    input  payload_t din_i,
    input  logic     rd_en_i,
    output payload_t dout_o,
    output logic     full_o,
    output logic     empty_o
);

    payload_t                  mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]  wr_ptr;
    logic [$clog2(DEPTH)-1:0]  rd_ptr;
    logic [$clog2(DEPTH):0]    count;  // occupancy

    assign full_o  = (count == DEPTH);
    assign empty_o = (count == '0);
    assign dout_o  = mem[rd_ptr];  // head, no read latency

    always_ff @(posedge adc_sampleclk) begin
        if (wr_en_i) begin
            mem[wr_ptr] <= din_i;
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en_i) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is a power of two
            end
            if (rd_en_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en_i, rd_en_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // writers and readers must respect the flags
    assert property (@(posedge adc_sampleclk) disable iff (reset) wr_en_i |-> !full_o);
    assert property (@(posedge adc_sampleclk) disable iff (reset) rd_en_i |-> !empty_o);

endmodule

// File: rtl/sample_packer.sv
`timescale 1ns/1ps

module sample_packer import scope_pkg::*; (
    input  logic    adc_sampleclk,
    input  logic    reset,
    input  logic    pack_en_i,
    input  logic    smp_empty_i,
    input  sample_t smp_dout_i,
    output logic    smp_rd_o,
    input  logic    word_full_i,
    output logic    word_wr_o,
    output word_t   word_o
);

    logic [1:0] smp_cnt;  // samples already in the assembly register

    assign smp_rd_o = pack_en_i && !smp_empty_i && !word_full_i;

    always_ff @(posedge adc_sampleclk) begin
        if (reset || !pack_en_i) begin
            smp_cnt   <= '0;  // drops any partial word between captures
            word_wr_o <= 1'b0;
        end else begin
            word_wr_o <= smp_rd_o && (smp_cnt == 2'(SAMPLES_PER_WORD - 1));
            if (smp_rd_o) begin
                smp_cnt <= (smp_cnt == 2'(SAMPLES_PER_WORD - 1)) ? '0 : smp_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (smp_rd_o) begin
            word_o <= {word_o[WORD_W-SAMPLE_W-1:0], smp_dout_i};  // oldest ends on top
        end
    end

    // full is checked at the third pop, the write lands a cycle later
    assert property (@(posedge adc_sampleclk) disable iff (reset) word_wr_o |-> !word_full_i);

endmodule

// File: rtl/scope_pkg.sv
package scope_pkg;

    localparam int SAMPLE_W         = 12;
    localparam int WORD_W           = 36;     // three samples per word
    localparam int SAMPLES_PER_WORD = 3;
    localparam int SAMPLE_DEPTH     = 64;     // presample_i must stay <= SAMPLE_DEPTH-4
    localparam int WORD_DEPTH       = 16;
    localparam int CREDIT_MAX       = 8;      // host byte buffer size
    localparam int CREDIT_W         = $clog2(CREDIT_MAX + 1);
    localparam int PRESAMPLE_W      = 8;
    localparam int MAXSAMP_W        = 16;
    localparam int DOWNSAMPLE_W     = 8;

    typedef logic [SAMPLE_W-1:0] sample_t;
    typedef logic [WORD_W-1:0]   word_t;  // oldest sample in bits 35:24

    typedef struct packed {
        logic [PRESAMPLE_W-1:0]  presample;
        logic [MAXSAMP_W-1:0]    max_samples;
        logic [DOWNSAMPLE_W-1:0] downsample;
        logic                    low_res;
        logic                    low_res_lsb;
        logic                    no_clip_errors;
    } capture_cfg_t;

    typedef struct packed {
        logic downsample_err;
        logic clip_err;
        logic presamp_err;
        logic overflow_err;
    } capture_err_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } byte_beat_t;

    typedef enum logic [2:0] {
        IDLE,
        PRESAMP_FILLING,
        PRESAMP_FULL,
        TRIGGERED,
        DONE
    } capture_state_t;

endpackage

// File: run_sim.sh
#!/bin/sh
# build and run the testbench, status follows the pass line
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal -f sources.f --top-module tb_adc_capture \
    -o tb_adc_capture &&
./obj_dir/tb_adc_capture | tee /dev/stderr | grep -q '^>>> PASS$' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: sources.f
+incdir+test
rtl/scope_pkg.sv
rtl/capture_regs.sv
rtl/capture_fsm.sv
rtl/sample_fifo.sv
rtl/sample_packer.sv
rtl/byte_reader.sv
rtl/adc_capture_top.sv
test/tb_adc_capture.sv

// File: test/capture_model.svh
typedef enum {M_IDLE, M_FILL, M_FULL, M_TRIG, M_DONE} model_state_e;

model_state_e m_state    = M_IDLE;
logic         m_arm_prev = 1'b0;
int           m_ds_cnt   = 0;
int           m_pre      = 0;
int           m_max      = 0;
int           m_ds       = 0;
int           m_pre_cnt  = 0;
int           m_kept     = 0;
bit           m_lowres   = 1'b0;
bit           m_lsb      = 1'b0;
bit           m_noclip   = 1'b0;
logic [2:0]   m_err      = '0;  // downsample, clip, presamp
sample_t      m_kept_q[$];      // samples expected to reach the host
logic [7:0]   exp_q[$];

// one call per clock edge, with the inputs the DUT sees at that edge
task automatic model_step(logic arm, logic go, sample_t d);
    model_state_e st;
    logic         keep;
    logic         wr;
    logic         arm_go;
    logic         full_before;
    logic [2:0]   evt;
    st          = m_state;
    keep        = (m_ds_cnt == 0);
    arm_go      = arm && !m_arm_prev && (st == M_IDLE);
    full_before = (m_pre_cnt == m_pre);
    wr          = 1'b0;
    evt         = '0;
    m_arm_prev  = arm;
    evt[2] = (st != M_IDLE) && (m_ds != 0) && (m_pre != 0);
    if (arm_go || m_ds_cnt == m_ds) m_ds_cnt = 0;
    else m_ds_cnt = m_ds_cnt + 1;
    case (st)
        M_IDLE: begin
            if (arm_go) begin
                m_pre     = int'(presample_i);
                m_max     = int'(max_samples_i);
                m_ds      = int'(downsample_i);
                m_lowres  = low_res_i;
                m_lsb     = low_res_lsb_i;
                m_noclip  = no_clip_errors_i;
                m_pre_cnt = 0;
                m_kept_q.delete();
                m_state   = M_FILL;
            end
        end
        M_FILL: begin
            wr = keep && !full_before;
            if (go) begin
                evt[0]  = !full_before;  // trigger before window filled
                m_kept  = m_pre_cnt + int'(wr);
                m_state = M_TRIG;
            end else if (wr && m_pre_cnt + 1 == m_pre) begin
                m_state = M_FULL;
            end
            if (wr) m_pre_cnt = m_pre_cnt + 1;
        end
        M_FULL: begin
            wr = keep;
            if (go) begin
                m_kept  = m_pre;
                m_state = M_TRIG;
            end
        end
        M_TRIG: begin
            if (keep) begin
                wr     = 1'b1;
                m_kept = m_kept + 1;
                if (m_kept == m_max) m_state = M_DONE;
            end
        end
        default: m_state = M_IDLE;
    endcase
    if (wr) begin
        m_kept_q.push_back(d);
        if (st == M_FULL) void'(m_kept_q.pop_front());  // window slides
        if (!m_noclip && (d == '0 || d == '1)) evt[1] = 1'b1;
    end
    if (clear_errors_i || arm_go) m_err = '0;
    else m_err = m_err | evt;
endtask

// samples to host bytes, hi-res is the 12-bit stream msb first
task automatic build_expected();
    logic [23:0] acc;
    int          nbits;
    acc   = '0;
    nbits = 0;
    exp_q.delete();
    foreach (m_kept_q[i]) begin
        if (m_lowres) begin
            exp_q.push_back(m_lsb ? m_kept_q[i][7:0] : m_kept_q[i][11:4]);
        end else begin
            acc   = {acc[11:0], m_kept_q[i]};
            nbits = nbits + 12;
            while (nbits >= 8) begin
                exp_q.push_back(8'(acc >> (nbits - 8)));
                nbits = nbits - 8;
            end
        end
    end
endtask

// File: test/tb_adc_capture.sv
`timescale 1ns/1ps

module tb_adc_capture import scope_pkg::*; ();

    logic                    adc_sampleclk;
    logic                    reset;
    logic                    arm_i;
    logic                    adc_capture_go_i;
    sample_t                 adc_datain_i;
    logic [PRESAMPLE_W-1:0]  presample_i;
    logic [MAXSAMP_W-1:0]    max_samples_i;
    logic [DOWNSAMPLE_W-1:0] downsample_i;
    logic                    low_res_i;
    logic                    low_res_lsb_i;
    logic                    no_clip_errors_i;
    logic                    clear_errors_i;
    logic                    credit_i;
    byte_beat_t              byte_o;
    logic                    adc_capture_stop_o;
    logic                    error_flag_o;
    capture_err_t            error_stat_o;

    logic [7:0] rx_q[$];
    int         beats    = 0;
    int         returned = 0;
    bit         withhold = 1'b0;
    bit         clip_all = 1'b0;  // drive full-scale samples

    `include "capture_model.svh"

    adc_capture_top uut (.*);

    initial begin
        adc_sampleclk = 1'b0;
        forever #20 adc_sampleclk = ~adc_sampleclk;
    end

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic step();
        @(posedge adc_sampleclk);
        #1;
        adc_datain_i = clip_all ? 12'hfff : 12'($urandom);
    endtask

    // host returns credits for bytes it has taken
    always @(posedge adc_sampleclk) begin
        #1;
        if (!reset && !withhold && beats > returned && ($urandom % 3) != 0) begin
            credit_i = 1'b1;
            returned = returned + 1;
        end else begin
            credit_i = 1'b0;
        end
    end

    always @(negedge adc_sampleclk) begin
        if (!reset) begin
            if (byte_o.valid) begin
                rx_q.push_back(byte_o.data);
                beats = beats + 1;
            end
            assert (beats <= CREDIT_MAX + returned)
                else abort_run($sformatf("error at %0t: %0d beats with %0d credits returned",
                                         $time, beats, returned));
            model_step(arm_i, adc_capture_go_i, adc_datain_i);
        end
    end

    task automatic wait_quiet();
        int idle;
        int cnt;
        idle = 0;
        cnt  = 0;
        while (idle < 30) begin
            idle = byte_o.valid ? 0 : idle + 1;
            step();
            cnt = cnt + 1;
            if (cnt > 20000) abort_run("timed out waiting for the byte stream to go quiet");
        end
    endtask

    task automatic run_capture(int pre, int max, int ds, bit lr, bit lsb, bit noclip,
                               int go_delay);
        int cnt;
        rx_q.delete();
        presample_i      = PRESAMPLE_W'(pre);
        max_samples_i    = MAXSAMP_W'(max);
        downsample_i     = DOWNSAMPLE_W'(ds);
        low_res_i        = lr;
        low_res_lsb_i    = lsb;
        no_clip_errors_i = noclip;
        arm_i            = 1'b1;
        step();
        arm_i = 1'b0;
        repeat (go_delay) step();
        adc_capture_go_i = 1'b1;
        step();
        adc_capture_go_i = 1'b0;
        cnt = 0;
        while (!adc_capture_stop_o) begin
            step();
            cnt = cnt + 1;
            if (cnt > 20000) abort_run("timed out waiting for capture stop");
        end
        if (!withhold) begin
            build_expected();
            cnt = 0;
            while (rx_q.size() < exp_q.size()) begin
                step();
                cnt = cnt + 1;
                if (cnt > 20000) abort_run("timed out waiting for capture bytes");
            end
            wait_quiet();
            assert (rx_q.size() == exp_q.size() && exp_q.size() == (lr ? max : max * 3 / 2))
                else abort_run($sformatf("error at %0t: got %0d bytes, expected %0d",
                                         $time, rx_q.size(), exp_q.size()));
            foreach (exp_q[i]) begin
                assert (rx_q[i] == exp_q[i])
                    else abort_run($sformatf("error at %0t: byte %0d is %h, expected %h",
                                             $time, i, rx_q[i], exp_q[i]));
            end
            assert (adc_capture_stop_o)
                else abort_run($sformatf("error at %0t: capture stop fell early", $time));
        end
    endtask

    task automatic check_errors(bit exp_ovf);
        assert (error_stat_o[3:1] == m_err && error_stat_o.overflow_err == exp_ovf
                && error_flag_o == (|m_err || exp_ovf))
            else abort_run($sformatf("error at %0t: error status %b, expected %b%b",
                                     $time, error_stat_o, m_err, exp_ovf));
    endtask

    initial begin
        void'($urandom(56));
        reset = 1'b1;
        arm_i = 1'b0;
        adc_capture_go_i = 1'b0;
        adc_datain_i = '0;
        presample_i = '0;
        max_samples_i = '0;
        downsample_i = '0;
        low_res_i = 1'b0;
        low_res_lsb_i = 1'b0;
        no_clip_errors_i = 1'b0;
        clear_errors_i = 1'b0;
        credit_i = 1'b0;
        repeat (10) @(posedge adc_sampleclk);
        #1;
        reset = 1'b0;
        run_capture(0, 30, 0, 1, 0, 0, 5);    // plain low-res
        check_errors(0);
        run_capture(10, 45, 0, 1, 0, 0, 30);  // presample window
        check_errors(0);
        run_capture(6, 48, 0, 0, 0, 0, 20);   // hi-res
        check_errors(0);
        run_capture(0, 24, 0, 1, 1, 0, 4);    // low bits
        check_errors(0);
        run_capture(0, 21, 2, 1, 0, 0, 6);    // downsampled
        check_errors(0);
        run_capture(4, 12, 1, 1, 0, 0, 20);
        check_errors(0);
        assert (error_stat_o.downsample_err)
            else abort_run($sformatf("error at %0t: downsample_err not set", $time));
        clip_all = 1'b1;
        run_capture(0, 9, 0, 1, 0, 0, 3);
        check_errors(0);
        assert (error_stat_o.clip_err)
            else abort_run($sformatf("error at %0t: clip_err not set", $time));
        run_capture(0, 9, 0, 1, 0, 1, 3);     // clip masked
        check_errors(0);
        clip_all = 1'b0;
        run_capture(20, 30, 0, 1, 0, 0, 3);   // early trigger
        check_errors(0);
        assert (error_stat_o.presamp_err)
            else abort_run($sformatf("error at %0t: presamp_err not set", $time));
        withhold = 1'b1;
        run_capture(0, 300, 0, 1, 0, 1, 2);   // host stalls, FIFO overflows
        assert (error_stat_o.overflow_err)
            else abort_run($sformatf("error at %0t: overflow_err not set", $time));
        withhold = 1'b0;
        wait_quiet();
        clear_errors_i = 1'b1;
        step();
        clear_errors_i = 1'b0;
        step();
        assert (error_stat_o == '0 && !error_flag_o)
            else abort_run($sformatf("error at %0t: errors not cleared", $time));
        $display(">>> PASS");
        $finish;
    end

endmodule
